// ==== all.f ====
bridge_pkg.sv
axi_req_capture.sv
apb_dev_decode.sv
bridge_ctrl.sv
axi_resp_regs.sv
axi2apb_top.sv
tb_checker.sv
tb_axi2apb.sv

// ==== apb_dev_decode.sv ====
`timescale 1ns/1ns

module apb_dev_decode #(
    parameter int data_width = 32,
    parameter int addr_width = 20
) (
    input  logic [addr_width-1:0]                req_addr,
    input  logic [bridge_pkg::apb_dev_count-1:0] pready,
    input  logic [bridge_pkg::apb_dev_count-1:0] pslverr,
    input  logic [data_width-1:0]                prdata [bridge_pkg::apb_dev_count],
    output logic [bridge_pkg::apb_dev_count-1:0] dev_sel,
    output logic                                 sel_ready,
    output logic                                 sel_slverr,
    output logic [data_width-1:0]                sel_rdata
);

    import bridge_pkg::*;

    localparam int idx_w = $clog2(apb_dev_count);

    logic [idx_w-1:0] dev_idx;

    assign dev_idx = req_addr[dev_idx_lsb +: idx_w];

    always_comb begin
        dev_sel = '0;
        dev_sel[dev_map[dev_idx]] = 1'b1;   // Fixed peripheral order
    end

    assign sel_ready  = |(pready & dev_sel);
    assign sel_slverr = |(pslverr & dev_sel);

    // Read data mux on the selected slot
    always_comb begin
        sel_rdata = '0;
        for (int i = 0; i < apb_dev_count; i++) begin
            if (dev_sel[i]) begin
                sel_rdata = prdata[i];
            end
        end
    end

endmodule

// ==== axi2apb_top.sv ====
`timescale 1ns/1ns

module axi2apb_top #(
    parameter int data_width = 32,
    parameter int addr_width = 20
) (
    input  logic                                 S_AXI_ACLK,
    input  logic                                 S_AXI_ARESETN,
    input  logic [addr_width-1:0]                S_AXI_AWADDR,
    input  logic [2:0]                           S_AXI_AWPROT,
    input  logic                                 S_AXI_AWVALID,
    output logic                                 S_AXI_AWREADY,
    input  logic [data_width-1:0]                S_AXI_WDATA,
    input  logic [(data_width/8)-1:0]            S_AXI_WSTRB,
    input  logic                                 S_AXI_WVALID,
    output logic                                 S_AXI_WREADY,
    output logic [1:0]                           S_AXI_BRESP,
    output logic                                 S_AXI_BVALID,
    input  logic                                 S_AXI_BREADY,
    input  logic [addr_width-1:0]                S_AXI_ARADDR,
    input  logic [2:0]                           S_AXI_ARPROT,
    input  logic                                 S_AXI_ARVALID,
    output logic                                 S_AXI_ARREADY,
    output logic [data_width-1:0]                S_AXI_RDATA,
    output logic [1:0]                           S_AXI_RRESP,
    output logic                                 S_AXI_RVALID,
    input  logic                                 S_AXI_RREADY,
    output logic [bridge_pkg::apb_dev_count-1:0] PSEL,
    output logic                                 PENABLE,
    output logic [addr_width-1:0]                PADDR,
    output logic                                 PWRITE,
    output logic [data_width-1:0]                PWDATA,
    input  logic [data_width-1:0]                PRDATA [bridge_pkg::apb_dev_count],
    input  logic [bridge_pkg::apb_dev_count-1:0] PREADY,
    input  logic [bridge_pkg::apb_dev_count-1:0] PSLVERR
);

    import bridge_pkg::*;

    logic                     accept_en;
    logic                     req_clear;
    logic                     wr_pending;
    logic                     rd_pending;
    logic [apb_dev_count-1:0] dev_sel;
    logic                     sel_ready;
    logic                     sel_slverr;
    logic [data_width-1:0]    sel_rdata;
    logic                     resp_load_w;
    logic                     resp_load_r;
    logic                     resp_err;
    logic                     resp_taken;

    // Held request drives PADDR and PWDATA directly
    axi_req_capture #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) axi_req_capture_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .accept_en     (accept_en),
        .req_clear     (req_clear),
        .awaddr        (S_AXI_AWADDR),
        .awvalid       (S_AXI_AWVALID),
        .wdata         (S_AXI_WDATA),
        .wvalid        (S_AXI_WVALID),
        .araddr        (S_AXI_ARADDR),
        .arvalid       (S_AXI_ARVALID),
        .awready       (S_AXI_AWREADY),
        .wready        (S_AXI_WREADY),
        .arready       (S_AXI_ARREADY),
        .req_addr      (PADDR),
        .req_wdata     (PWDATA),
        .wr_pending    (wr_pending),
        .rd_pending    (rd_pending)
    );

    apb_dev_decode #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) apb_dev_decode_i (
        .req_addr   (PADDR),
        .pready     (PREADY),
        .pslverr    (PSLVERR),
        .prdata     (PRDATA),
        .dev_sel    (dev_sel),
        .sel_ready  (sel_ready),
        .sel_slverr (sel_slverr),
        .sel_rdata  (sel_rdata)
    );

    bridge_ctrl bridge_ctrl_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr_pending    (wr_pending),
        .rd_pending    (rd_pending),
        .dev_sel       (dev_sel),
        .sel_ready     (sel_ready),
        .sel_slverr    (sel_slverr),
        .resp_taken    (resp_taken),
        .accept_en     (accept_en),
        .req_clear     (req_clear),
        .psel          (PSEL),
        .penable       (PENABLE),
        .pwrite        (PWRITE),
        .resp_load_w   (resp_load_w),
        .resp_load_r   (resp_load_r),
        .resp_err      (resp_err)
    );

    axi_resp_regs #(
        .data_width (data_width)
    ) axi_resp_regs_i (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .resp_load_w   (resp_load_w),
        .resp_load_r   (resp_load_r),
        .resp_err      (resp_err),
        .sel_rdata     (sel_rdata),
        .bready        (S_AXI_BREADY),
        .rready        (S_AXI_RREADY),
        .bvalid        (S_AXI_BVALID),
        .bresp         (S_AXI_BRESP),
        .rvalid        (S_AXI_RVALID),
        .rresp         (S_AXI_RRESP),
        .rdata         (S_AXI_RDATA),
        .resp_taken    (resp_taken)
    );

endmodule

// ==== axi2apb_trace.txt ====
# op (0 write, 1 read, 2 write with read raised together) addr wdata exp_rdata
# exp_resp (0 okay, 2 slverr) bp_cycles w_delay; addr and data in hex
0 00004 11110000 00000000 0 0 0
1 00004 00000000 11110000 0 0 0
0 02004 22220001 00000000 0 1 2
0 04004 33330002 00000000 0 0 1
0 06004 44440003 00000000 0 0 0
0 08004 55550004 00000000 0 2 0
0 0a004 66660005 00000000 0 0 3
0 0c004 77770006 00000000 0 0 0
0 0e004 88880007 00000000 0 0 0
1 02004 00000000 22220001 0 3 0
1 0a004 00000000 66660005 0 0 0
0 04f04 deadbeef 00000000 2 1 0
1 04f04 00000000 00000000 2 2 0
1 04004 00000000 33330002 0 0 0
2 0c008 9999000a 9999000a 0 1 2
1 0e004 00000000 88880007 0 4 0

// ==== axi_req_capture.sv ====
`timescale 1ns/1ns

module axi_req_capture #(
    parameter int data_width = 32,
    parameter int addr_width = 20
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  accept_en,
    input  logic                  req_clear,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    input  logic [data_width-1:0] wdata,
    input  logic                  wvalid,
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  awready,
    output logic                  wready,
    output logic                  arready,
    output logic [addr_width-1:0] req_addr,
    output logic [data_width-1:0] req_wdata,
    output logic                  wr_pending,
    output logic                  rd_pending
);

    logic aw_seen;
    logic w_seen;
    logic rd_held;
    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic slot_free;

    // Out of reset with nothing held and the controller idle
    assign slot_free = S_AXI_ARESETN && accept_en && !rd_held && !(aw_seen && w_seen);

    assign awready = slot_free && !aw_seen;
    assign wready  = slot_free && !w_seen;
    // A read waits while any write half is present
    assign arready = slot_free && !aw_seen && !w_seen && !awvalid && !wvalid;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    assign wr_pending = aw_seen && w_seen;
    assign rd_pending = rd_held;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            rd_held <= 1'b0;
        end else if (req_clear) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            rd_held <= 1'b0;
        end else begin
            if (aw_hs) aw_seen <= 1'b1;
            if (w_hs) w_seen <= 1'b1;
            if (ar_hs) rd_held <= 1'b1;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs)
            req_addr <= awaddr[addr_width-1:0];
        else if (ar_hs)
            req_addr <= araddr[addr_width-1:0];
        if (w_hs)
            req_wdata <= wdata;
    end

    a_one_direction: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(wr_pending && rd_pending))
        else $error("write and read pending together");

endmodule

// ==== axi_resp_regs.sv ====
`timescale 1ns/1ns

module axi_resp_regs #(
    parameter int data_width = 32
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  logic                  resp_load_w,
    input  logic                  resp_load_r,
    input  logic                  resp_err,
    input  logic [data_width-1:0] sel_rdata,
    input  logic                  bready,
    input  logic                  rready,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    output logic                  rvalid,
    output logic [1:0]            rresp,
    output logic [data_width-1:0] rdata,
    output logic                  resp_taken
);

    import bridge_pkg::*;

    assign resp_taken = (bvalid && bready) || (rvalid && rready);

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (resp_load_w)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (resp_load_r)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Response fields only move on a load
    always_ff @(posedge S_AXI_ACLK) begin
        if (resp_load_w)
            bresp <= resp_err ? resp_slverr : resp_okay;
        if (resp_load_r) begin
            rresp <= resp_err ? resp_slverr : resp_okay;
            rdata <= sel_rdata;
        end
    end

    a_one_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(bvalid && rvalid))
        else $error("B and R valid together");

endmodule

// ==== bridge_ctrl.sv ====
`timescale 1ns/1ns

module bridge_ctrl (
    input  logic                                 S_AXI_ACLK,
    input  logic                                 S_AXI_ARESETN,
    input  logic                                 wr_pending,
    input  logic                                 rd_pending,
    input  logic [bridge_pkg::apb_dev_count-1:0] dev_sel,
    input  logic                                 sel_ready,
    input  logic                                 sel_slverr,
    input  logic                                 resp_taken,
    output logic                                 accept_en,
    output logic                                 req_clear,
    output logic [bridge_pkg::apb_dev_count-1:0] psel,
    output logic                                 penable,
    output logic                                 pwrite,
    output logic                                 resp_load_w,
    output logic                                 resp_load_r,
    output logic                                 resp_err
);

    import bridge_pkg::*;

    bridge_state_e state;

    assign accept_en   = (state == IDLE);
    assign resp_load_w = (state == WR_ACCESS) && sel_ready;
    assign resp_load_r = (state == RD_ACCESS) && sel_ready;
    assign resp_err    = sel_slverr;   // Sampled with the load pulse
    assign req_clear   = ((state == WR_RESP) || (state == RD_RESP)) && resp_taken;

    always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
        if (!S_AXI_ARESETN) begin
            state   <= IDLE;
            psel    <= '0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_pending) begin   // Write goes first
                        state  <= WR_SETUP;
                        psel   <= dev_sel;
                        pwrite <= 1'b1;
                    end else if (rd_pending) begin
                        state  <= RD_SETUP;
                        psel   <= dev_sel;
                        pwrite <= 1'b0;
                    end
                end

                WR_SETUP: begin
                    state   <= WR_ACCESS;
                    penable <= 1'b1;
                end

                WR_ACCESS: begin
                    if (sel_ready) begin
                        state   <= WR_RESP;
                        psel    <= '0;
                        penable <= 1'b0;
                    end
                end

                WR_RESP: begin
                    if (resp_taken) state <= IDLE;
                end

                RD_SETUP: begin
                    state   <= RD_ACCESS;
                    penable <= 1'b1;
                end

                RD_ACCESS: begin
                    if (sel_ready) begin
                        state   <= RD_RESP;
                        psel    <= '0;
                        penable <= 1'b0;
                    end
                end

                RD_RESP: begin
                    if (resp_taken) state <= IDLE;
                end

                default: begin
                    state   <= IDLE;
                    psel    <= '0;
                    penable <= 1'b0;
                end
            endcase
        end
    end

    a_enable_needs_sel: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        penable |-> (psel != '0))
        else $error("PENABLE without PSEL");

    // Slave choice is frozen through the access phase
    a_sel_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        penable |-> $stable(psel))
        else $error("PSEL changed during access");

endmodule

// ==== bridge_pkg.sv ====
package bridge_pkg;

    localparam int apb_dev_count = 8;
    localparam int dev_idx_lsb   = 13;   // Lowest bit of the 3-bit device index

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WR_SETUP  = 3'd1,
        WR_ACCESS = 3'd2,
        WR_RESP   = 3'd3,
        RD_SETUP  = 3'd4,
        RD_ACCESS = 3'd5,
        RD_RESP   = 3'd6
    } bridge_state_e;

    // Index value to PSEL bit
    localparam int unsigned dev_map [apb_dev_count] = '{
        0,   // Timer
        3,   // SPI
        4,   // I2C0
        5,   // I2C1
        1,   // UART0
        2,   // UART1
        6,   // GPIO0
        7    // GPIO1
    };

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module tb_axi2apb -f all.f -o sim_axi2apb
out=$(./obj_dir/sim_axi2apb)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully"

// ==== tb_axi2apb.sv ====
`timescale 1ns/1ns

module tb_axi2apb;

    localparam int data_width = 32;
    localparam int addr_width = 20;
    localparam int max_lines = 64;

    logic                  clk;
    logic                  resetn;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic [data_width-1:0] wdata;
    logic                  wvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  rready;
    logic                  awready;
    logic                  wready;
    logic                  arready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  rvalid;
    logic [1:0]            rresp;
    logic [data_width-1:0] rdata;
    logic [7:0]            psel;
    logic                  penable;
    logic [addr_width-1:0] paddr;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [data_width-1:0] prdata_bus [8] = '{default: '0};
    logic [7:0]            pready_bus = '0;
    logic [7:0]            pslverr_bus = '0;
    logic [1:0]            wait_cnt [8] = '{default: '0};
    logic [31:0]           mem [8][16];
    logic [31:0]           lfsr = 32'h07ccbd3e;

    int          n_lines = 0;
    int          n_records = 0;
    bit          trace_loaded = 0;
    int          t_op [max_lines];
    logic [31:0] t_addr [max_lines];
    logic [31:0] t_wdata [max_lines];
    logic [31:0] t_rdata [max_lines];
    int          t_resp [max_lines];
    int          t_bp [max_lines];
    int          t_wdly [max_lines];

    axi2apb_top axi2apb_top_i (
        .S_AXI_ACLK    (clk),
        .S_AXI_ARESETN (resetn),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWPROT  (3'b000),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (4'hf),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_BREADY  (bready),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARPROT  (3'b000),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid),
        .S_AXI_RREADY  (rready),
        .PSEL          (psel),
        .PENABLE       (penable),
        .PADDR         (paddr),
        .PWRITE        (pwrite),
        .PWDATA        (pwdata),
        .PRDATA        (prdata_bus),
        .PREADY        (pready_bus),
        .PSLVERR       (pslverr_bus)
    );

    tb_checker #(
        .data_width (data_width),
        .addr_width (addr_width)
    ) checker_i (
        .S_AXI_ACLK    (clk),
        .S_AXI_ARESETN (resetn),
        .awready       (awready),
        .wready        (wready),
        .arready       (arready),
        .psel          (psel),
        .penable       (penable),
        .paddr         (paddr),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .rresp         (rresp),
        .rdata         (rdata)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32,22,2,1
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Eight APB slaves of 16 words each
    always @(posedge clk) begin
        logic [1:0] wait_n;
        logic       err;
        if (!resetn) begin
            for (int i = 0; i < 8; i++)
                for (int j = 0; j < 16; j++)
                    mem[i][j] <= 32'hc0de0000 | 32'(i * 256 + j);
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (psel[i] && !penable) begin
                    lfsr = lfsr_next(lfsr);
                    wait_n[0] = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    wait_n[1] = lfsr[0];
                    err = (paddr[11:8] == 4'hf);   // Error window
                    pslverr_bus[i] <= err;
                    prdata_bus[i]  <= err ? '0 : mem[i][paddr[5:2]];
                    pready_bus[i]  <= (wait_n == 2'd0);
                    wait_cnt[i]    <= wait_n;
                end else if (psel[i] && penable) begin
                    if (pready_bus[i]) begin
                        if (pwrite && !pslverr_bus[i])
                            mem[i][paddr[5:2]] <= pwdata;
                        pready_bus[i]  <= 1'b0;
                        pslverr_bus[i] <= 1'b0;
                    end else begin
                        if (wait_cnt[i] == 2'd1)
                            pready_bus[i] <= 1'b1;
                        wait_cnt[i] <= wait_cnt[i] - 2'd1;
                    end
                end
            end
        end
    end

    task automatic do_write(input logic [31:0] a, input logic [31:0] d,
                            input int wdly, input int bp);
        bit aw_done;
        bit w_done;
        int cnt;
        aw_done = 0;
        w_done  = 0;
        cnt     = 0;
        @(posedge clk);
        awaddr  <= a[addr_width-1:0];
        awvalid <= 1'b1;
        if (wdly == 0) begin
            wdata  <= d;
            wvalid <= 1'b1;
        end
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awvalid && awready) begin
                aw_done = 1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                w_done = 1;
                wvalid <= 1'b0;
            end
            cnt++;
            if (!w_done && !wvalid && cnt >= wdly) begin   // Late W
                wdata  <= d;
                wvalid <= 1'b1;
            end
        end
        do @(posedge clk); while (!bvalid);
        repeat (bp) @(posedge clk);
        bready <= 1'b1;
        do @(posedge clk); while (!(bvalid && bready));
        bready <= 1'b0;
    endtask

    task automatic do_read(input logic [31:0] a, input int bp);
        @(posedge clk);
        araddr  <= a[addr_width-1:0];
        arvalid <= 1'b1;
        do @(posedge clk); while (!(arvalid && arready));
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        repeat (bp) @(posedge clk);
        rready <= 1'b1;
        do @(posedge clk); while (!(rvalid && rready));
        rready <= 1'b0;
    endtask

    task automatic run_entry(input int t);
        case (t_op[t])
            0: begin
                checker_i.push_expect(1'b1, t_addr[t], t_wdata[t], 2'(t_resp[t]));
                do_write(t_addr[t], t_wdata[t], t_wdly[t], t_bp[t]);
            end
            1: begin
                checker_i.push_expect(1'b0, t_addr[t], t_rdata[t], 2'(t_resp[t]));
                do_read(t_addr[t], t_bp[t]);
            end
            default: begin
                // Read raised alongside the write and served after it
                checker_i.push_expect(1'b1, t_addr[t], t_wdata[t], 2'(t_resp[t]));
                checker_i.push_expect(1'b0, t_addr[t], t_rdata[t], 2'(t_resp[t]));
                fork
                    do_write(t_addr[t], t_wdata[t], t_wdly[t], 0);
                    do_read(t_addr[t], t_bp[t]);
                join
            end
        endcase
    endtask

    initial begin
        int          fd;
        string       line;
        int          op;
        int          rs;
        int          bp;
        int          wd;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] r;
        resetn  <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        fd = $fopen("axi2apb_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file axi2apb_trace.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            while (!$feof(fd) && n_lines < max_lines) begin
                if ($fgets(line, fd) == 0)
                    break;
                if (line.len() == 0 || line.getc(0) == "#")
                    continue;
                if ($sscanf(line, "%d %h %h %h %d %d %d", op, a, w, r, rs, bp, wd) == 7) begin
                    t_op[n_lines]    = op;
                    t_addr[n_lines]  = a;
                    t_wdata[n_lines] = w;
                    t_rdata[n_lines] = r;
                    t_resp[n_lines]  = rs;
                    t_bp[n_lines]    = bp;
                    t_wdly[n_lines]  = wd;
                    n_records += (op == 2) ? 2 : 1;
                    n_lines++;
                end
            end
            $fclose(fd);
            trace_loaded = 1;
            repeat (5) @(posedge clk);
            resetn <= 1'b1;
            repeat (2) @(posedge clk);
            for (int t = 0; t < n_lines; t++)
                run_entry(t);
            repeat (4) @(posedge clk);
            $display("%0d passed, %0d failed", checker_i.pass_count, checker_i.fail_count);
            if (n_records > 0 && checker_i.fail_count == 0 &&
                checker_i.pass_count == n_records)
                $display("Simulation completed successfully");
            else
                $display("Simulation failed");
            $finish;
        end
    end

    // Budget of 40 cycles per trace line
    initial begin
        wait (trace_loaded);
        #(longint'(n_lines) * 40 * 40 + 400);
        $display("Timeout: the run hung on test %0d", checker_i.test_num + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker #(
    parameter int data_width = 32,
    parameter int addr_width = 20
) (
    input logic                  S_AXI_ACLK,
    input logic                  S_AXI_ARESETN,
    input logic                  awready,
    input logic                  wready,
    input logic                  arready,
    input logic [7:0]            psel,
    input logic                  penable,
    input logic [addr_width-1:0] paddr,
    input logic                  pwrite,
    input logic [data_width-1:0] pwdata,
    input logic                  bvalid,
    input logic                  bready,
    input logic [1:0]            bresp,
    input logic                  rvalid,
    input logic                  rready,
    input logic [1:0]            rresp,
    input logic [data_width-1:0] rdata
);

    // Decode index to PSEL bit per the device map
    localparam int psel_bit [8] = '{0, 3, 4, 5, 1, 2, 6, 7};

    bit                    exp_wr [$];
    logic [31:0]           exp_addr [$];
    logic [31:0]           exp_data [$];
    logic [1:0]            exp_resp [$];
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    test_num = 0;
    bit                    test_bad = 0;
    bit                    was_reset = 1;
    logic [7:0]            prev_psel;
    logic                  prev_pen;
    logic [addr_width-1:0] prev_paddr;
    logic                  prev_pwrite;
    logic [data_width-1:0] prev_pwdata;
    logic                  prev_bhold;
    logic                  prev_rhold;
    logic [1:0]            prev_bresp;
    logic [1:0]            prev_rresp;
    logic [data_width-1:0] prev_rdata;

    task automatic push_expect(input bit is_wr, input logic [31:0] addr,
                               input logic [31:0] data, input logic [1:0] resp);
        exp_wr.push_back(is_wr);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_resp.push_back(resp);
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL %0t ns: %s", $time, msg);
        test_bad = 1;
    endtask

    task automatic check_resp(input bit is_wr, input logic [1:0] resp,
                              input logic [data_width-1:0] data);
        bit          w;
        logic [31:0] a;
        logic [31:0] d;
        logic [1:0]  r;
        if (exp_wr.size() == 0) begin
            report_fail("response with no transaction expected");
            a = '0;
        end else begin
            w = exp_wr.pop_front();
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            r = exp_resp.pop_front();
            if (w != is_wr)
                report_fail("response on the wrong channel");
            if (resp != r)
                report_fail($sformatf("resp %0d, expected %0d", resp, r));
            if (!is_wr && data != d)
                report_fail($sformatf("rdata %h, expected %h", data, d));
        end
        test_num++;
        if (test_bad)
            fail_count++;
        else
            pass_count++;
        $display("test %0d: %s 0x%05h %s", test_num, is_wr ? "write" : "read", a,
                 test_bad ? "failed" : "ok");
        test_bad = 0;
    endtask

    always @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            if (awready || wready || arready)
                report_fail("request ready high during reset");
            was_reset  <= 1;
            prev_psel  <= '0;
            prev_pen   <= 1'b0;
            prev_bhold <= 1'b0;
            prev_rhold <= 1'b0;
        end else begin
            if (was_reset && (psel != 0 || penable))
                report_fail("PSEL or PENABLE high after reset");
            was_reset <= 0;
            // SETUP phase begins
            if (psel != 0 && prev_psel == 0) begin
                if (penable)
                    report_fail("PENABLE high in SETUP");
                if (exp_addr.size() == 0) begin
                    report_fail("APB transfer with no transaction expected");
                end else begin
                    if (psel != (8'd1 << psel_bit[exp_addr[0][15:13]]))
                        report_fail($sformatf("PSEL %b for address %h", psel, exp_addr[0]));
                    if (paddr != exp_addr[0][addr_width-1:0])
                        report_fail($sformatf("PADDR %h, expected %h", paddr, exp_addr[0]));
                    if (pwrite != exp_wr[0])
                        report_fail("PWRITE wrong");
                    if (exp_wr[0] && pwdata != exp_data[0])
                        report_fail($sformatf("PWDATA %h, expected %h", pwdata, exp_data[0]));
                end
            end
            if (prev_psel != 0 && !prev_pen && (!penable || psel != prev_psel))
                report_fail("PENABLE did not follow PSEL by one cycle");
            if (psel != 0 && prev_psel != 0 && (psel != prev_psel || paddr != prev_paddr ||
                pwrite != prev_pwrite || pwdata != prev_pwdata))
                report_fail("APB select, address or data moved during transfer");
            if ((bvalid || rvalid) && psel != 0)
                report_fail("PSEL high while a response is pending");
            if ((psel != 0 || bvalid || rvalid) && (awready || wready || arready))
                report_fail("request ready high while a transfer is in progress");
            if (prev_bhold && (!bvalid || bresp != prev_bresp))
                report_fail("B channel changed under back-pressure");
            if (prev_rhold && (!rvalid || rresp != prev_rresp || rdata != prev_rdata))
                report_fail("R channel changed under back-pressure");
            if (bvalid && bready)
                check_resp(1'b1, bresp, '0);
            if (rvalid && rready)
                check_resp(1'b0, rresp, rdata);
            prev_psel   <= psel;
            prev_pen    <= penable;
            prev_paddr  <= paddr;
            prev_pwrite <= pwrite;
            prev_pwdata <= pwdata;
            prev_bhold  <= bvalid && !bready;
            prev_rhold  <= rvalid && !rready;
            prev_bresp  <= bresp;
            prev_rresp  <= rresp;
            prev_rdata  <= rdata;
        end
    end

endmodule
